//--- Makefile
# Verilator build and run for the clock alignment project

VERILATOR ?= verilator
TOP       ?= tb_clk_align
FILELIST  ?= clk_align.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= RESULT: PASS

SRCS := $(wildcard design/*.sv bench/*.sv include/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the log holds the pass line
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/clk_align_assertions.sv
`include "clk_align_cfg.svh"

module clk_align_assertions
    import clk_align_pkg::*;
(
    input logic                              clk_9x,
    input logic                              rst_9x,
    input skew_cmd_t                         skew_cmd,
    input logic                              skew_ack,
    input logic                              locked,
    input logic                              fail,
    input logic [$clog2(`MAX_STEPS + 1)-1:0] step_cnt
);

    localparam int STEP_W = $clog2(`MAX_STEPS + 1);

    // strobe and direction hold until the pattern acks
    en_held: assert property (@(posedge clk_9x) disable iff (rst_9x)
        (skew_cmd.en && !skew_ack) |=> (skew_cmd.en && $stable(skew_cmd.dir)))
        else $error("skew strobe dropped or changed direction before ack");

    // ack only follows a live strobe
    ack_needs_en: assert property (@(posedge clk_9x) disable iff (rst_9x)
        (!skew_cmd.en && !skew_ack) |=> !skew_ack)
        else $error("skew ack rose without a strobe");

    status_excl: assert property (@(posedge clk_9x) disable iff (rst_9x)
        !(locked && fail))
        else $error("locked and fail high together");

    step_limit: assert property (@(posedge clk_9x) disable iff (rst_9x)
        step_cnt <= STEP_W'(`MAX_STEPS))
        else $error("step counter beyond the step limit");

endmodule

// controller side sees the full set
bind alignment_ctrl clk_align_assertions u_ctrl_chk (
    .clk_9x   (clk_9x),
    .rst_9x   (rst_9x),
    .skew_cmd (skew_cmd),
    .skew_ack (skew_ack),
    .locked   (locked),
    .fail     (fail),
    .step_cnt (step_cnt)
);

// pattern side only has the handshake
bind sensor_clk_pattern clk_align_assertions u_pat_chk (
    .clk_9x   (clk_9x),
    .rst_9x   (rst_9x),
    .skew_cmd (skew_cmd),
    .skew_ack (skew_ack),
    .locked   (1'b0),
    .fail     (1'b0),
    .step_cnt ('0)
);

//--- bench/tb_clk_align.sv
`include "clk_align_cfg.svh"

module tb_clk_align;

    localparam int HIST_LEN   = 64;     // sample history longer than a period plus a word
    localparam int WAIT_LIMIT = 2000;   // cycles allowed for one lock or fail

    typedef struct packed {
        int locked;
        int fail;
        int dec_n;        // dec moves of the clock edge
        int inc_n;        // inc moves of the clock edge
        int final_edge;   // received edge after lock or -1
        int cleared;      // status dropped on the next start
    } lock_result_t;

    logic               clk_9x;
    logic               rst_9x;
    logic               start;
    logic [`WORD_W-1:0] rx_word;
    logic [`WORD_W-1:0] clk_word;
    logic               busy;
    logic               locked;
    logic               fail;

    int                  seed         = 32'hff92;
    int                  chan_delay   = 0;            // channel delay in samples
    bit                  rx_zero      = 1'b0;         // channel cut so nothing comes back
    int                  err_cnt      = 0;
    int                  test_cnt     = 0;
    int                  last_edge    = `HALF_PAT;    // rising edge seen on clk_word
    int                  exp_clk_edge = `HALF_PAT;    // where the clock edge should sit now
    int                  dec_moves    = 0;
    int                  inc_moves    = 0;
    bit                  first_seen   = 1'b0;
    logic [`PAT_LEN-1:0] first_frame;                 // first full frame after reset

    lock_result_t exp_q[$];
    lock_result_t act_q[$];
    string        name_q[$];

    clk_align_top dut0 (
        .clk_9x   (clk_9x),
        .rst_9x   (rst_9x),
        .start    (start),
        .rx_word  (rx_word),
        .clk_word (clk_word),
        .busy     (busy),
        .locked   (locked),
        .fail     (fail)
    );

    initial begin
        clk_9x = 1'b0;
        forever #2 clk_9x = ~clk_9x;
    end

    // lowest i with sample i high and sample i-1 low or -1 for a flat frame
    function automatic int rise_pos(input logic [`PAT_LEN-1:0] s);
        for (int i = 0; i < `PAT_LEN; i++) begin
            if (s[i] && !s[(i + `PAT_LEN - 1) % `PAT_LEN]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // expected outcome of one run with err walked back to zero the short way
    function automatic lock_result_t ref_lock(input int rx_edge, input bit no_data);
        lock_result_t r;
        int           e;
        int           err;
        r       = '0;
        r.fail  = no_data ? 1 : 0;
        r.locked = no_data ? 0 : 1;
        r.final_edge = no_data ? -1 : `TARGET_EDGE;
        r.cleared = 1;   // LOCKED and FAIL both leave on start
        e = rx_edge;
        for (int n = 0; n < `MAX_STEPS && !no_data; n++) begin
            err = (e - `TARGET_EDGE + `PAT_LEN) % `PAT_LEN;
            if (err == 0) begin
                break;
            end else if (err <= `HALF_PAT) begin
                e = (e + `PAT_LEN - 1) % `PAT_LEN;   // late edge is pulled back
                r.dec_n++;
            end else begin
                e = (e + 1) % `PAT_LEN;
                r.inc_n++;
            end
        end
        return r;
    endfunction

    function automatic int delay_for_err(input int err);
        return (`TARGET_EDGE + err - exp_clk_edge + 2 * `PAT_LEN) % `PAT_LEN;
    endfunction

    task automatic check_val(input string name, input longint exp_v, input longint act_v);
        if (exp_v !== act_v) begin
            $display("error @%0t: %s expected %0d got %0d", $time, name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    // count edge moves between finished clk_word frames
    task automatic track_edge(input logic [`PAT_LEN-1:0] frame);
        int e;
        int delta;
        e = rise_pos(frame);
        if (!first_seen) begin
            first_frame = frame;
            first_seen  = 1'b1;
        end
        if (e < 0) begin
            $display("clk_word frame without a rising edge at time %0t", $time);
            err_cnt++;
        end else begin
            delta = (e - last_edge + `PAT_LEN) % `PAT_LEN;
            if (delta == 1) begin
                inc_moves++;
            end else if (delta == `PAT_LEN - 1) begin
                dec_moves++;
            end else if (delta != 0) begin
                $display("clk_word edge jumped from %0d to %0d at time %0t", last_edge, e, $time);
                err_cnt++;
            end
            last_edge = e;
        end
    endtask

    task automatic pulse_start();
        @(posedge clk_9x);
        #1 start = 1'b1;
        @(posedge clk_9x);
        #1 start = 1'b0;
    endtask

    task automatic wait_done(input string tname);
        bit ok;
        ok = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(posedge clk_9x);
            #1 ok = locked || fail;
        end
        if (!ok) begin
            $display("test %s timed out waiting for locked or fail", tname);
            err_cnt++;
        end
    endtask

    task automatic run_test(input string tname, input int delay, input bit no_data);
        lock_result_t a_r;
        int           dec0;
        int           inc0;
        chan_delay = delay;
        rx_zero    = no_data;
        repeat (2 * `FRAME_SLOTS) @(posedge clk_9x);   // let the channel refill
        #1 exp_q.push_back(ref_lock((exp_clk_edge + delay) % `PAT_LEN, no_data));
        if (!no_data) begin
            exp_clk_edge = (`TARGET_EDGE - delay + `PAT_LEN) % `PAT_LEN;   // lock leaves it here
        end
        dec0 = dec_moves;
        inc0 = inc_moves;
        pulse_start();
        wait_done(tname);
        a_r.locked     = locked ? 1 : 0;
        a_r.fail       = fail ? 1 : 0;
        a_r.dec_n      = dec_moves - dec0;
        a_r.inc_n      = inc_moves - inc0;
        a_r.final_edge = locked ? (last_edge + delay) % `PAT_LEN : -1;
        pulse_start();                                   // restart must clear status
        a_r.cleared    = (!locked && !fail && busy) ? 1 : 0;
        wait_done(tname);
        act_q.push_back(a_r);
        name_q.push_back(tname);
    endtask

    // sensor channel replays clock samples delayed by chan_delay
    initial begin : channel
        logic                hist [HIST_LEN];
        logic [`WORD_W-1:0]  rx_bits;
        logic [`PAT_LEN-1:0] frame;
        int                  wr_ptr;
        int                  slot;
        bit                  in_rst;
        for (int i = 0; i < HIST_LEN; i++) begin
            hist[i] = 1'b0;
        end
        wr_ptr  = 0;
        slot    = 0;
        frame   = '0;
        rx_word = '0;
        forever begin
            @(posedge clk_9x);
            in_rst = rst_9x;   // what the DUT saw on this edge
            #1;
            if (in_rst) begin
                slot = 0;      // first word out of reset is slot 0
            end else begin
                for (int j = 0; j < `WORD_W; j++) begin
                    hist[(wr_ptr + j) % HIST_LEN] = clk_word[j];
                    rx_bits[j] = hist[(wr_ptr + j + HIST_LEN - chan_delay) % HIST_LEN];
                end
                rx_word = rx_zero ? '0 : rx_bits;
                wr_ptr  = (wr_ptr + `WORD_W) % HIST_LEN;
                frame[slot*`WORD_W +: `WORD_W] = clk_word;
                if (slot == `FRAME_SLOTS - 1) begin
                    track_edge(frame);
                    slot = 0;
                end else begin
                    slot++;
                end
            end
        end
    end

    // compare process takes one record per finished run
    initial begin : compare
        lock_result_t e_r;
        lock_result_t a_r;
        string        tname;
        int           errs0;
        forever begin
            @(posedge clk_9x);
            while (exp_q.size() > 0 && act_q.size() > 0) begin
                e_r   = exp_q.pop_front();
                a_r   = act_q.pop_front();
                tname = name_q.pop_front();
                errs0 = err_cnt;
                check_val("locked", longint'(e_r.locked), longint'(a_r.locked));
                check_val("fail", longint'(e_r.fail), longint'(a_r.fail));
                check_val("dec_moves", longint'(e_r.dec_n), longint'(a_r.dec_n));
                check_val("inc_moves", longint'(e_r.inc_n), longint'(a_r.inc_n));
                check_val("final_edge", longint'(e_r.final_edge), longint'(a_r.final_edge));
                check_val("status_cleared", longint'(e_r.cleared), longint'(a_r.cleared));
                test_cnt++;
                $display("test %s: %s", tname, (err_cnt == errs0) ? "ok" : "mismatch");
            end
        end
    end

    initial begin : main
        logic [`PAT_LEN-1:0] exp_frame;
        int                  errs0;
        rst_9x = 1'b1;
        start  = 1'b0;
        repeat (4) @(posedge clk_9x);
        #1 rst_9x = 1'b0;

        // reset pattern is 18 low samples then 18 high
        errs0 = err_cnt;
        for (int i = 0; i < `PAT_LEN; i++) begin
            exp_frame[i] = (i >= `HALF_PAT);
        end
        for (int n = 0; n < 4 * `FRAME_SLOTS && !first_seen; n++) begin
            @(posedge clk_9x);
            #1;
        end
        if (!first_seen) begin
            $display("no full clk_word frame came out after reset");
            err_cnt++;
        end else begin
            check_val("clk_word", longint'(exp_frame), longint'(first_frame));
        end
        check_val("busy", 0, longint'(busy));
        check_val("locked", 0, longint'(locked));
        check_val("fail", 0, longint'(fail));
        test_cnt++;
        $display("test reset_pattern: %s", (err_cnt == errs0) ? "ok" : "mismatch");

        run_test("already_aligned", delay_for_err(0), 1'b0);
        run_test("lock_dec", delay_for_err(5), 1'b0);
        run_test("lock_inc", delay_for_err(30), 1'b0);
        run_test("lock_dec_half", delay_for_err(`HALF_PAT), 1'b0);
        for (int n = 0; n < 2; n++) begin
            run_test($sformatf("lock_rand_%0d", n), $unsigned($random(seed)) % `PAT_LEN, 1'b0);
        end
        for (int n = 0; n < 3; n++) begin
            run_test($sformatf("no_edge_%0d", n), $unsigned($random(seed)) % `PAT_LEN, 1'b1);
        end

        for (int n = 0; n < 10 && exp_q.size() > 0; n++) begin
            @(posedge clk_9x);
        end
        if (exp_q.size() > 0) begin
            $display("some results were never compared");
            err_cnt++;
        end
        $display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- clk_align.f
+incdir+include
design/clk_align_pkg.sv
design/sensor_clk_pattern.sv
design/rx_edge_finder.sv
design/alignment_ctrl.sv
design/clk_align_top.sv
bench/clk_align_assertions.sv
bench/tb_clk_align.sv

//--- design/alignment_ctrl.sv
`include "clk_align_cfg.svh"

module alignment_ctrl
    import clk_align_pkg::*;
(
    input  logic      clk_9x,
    input  logic      rst_9x,
    input  logic      start,        // one-cycle pulse
    input  edge_rpt_t rpt,          // edge report from rx side
    input  logic      rpt_valid,
    input  logic      skew_ack,     // from pattern generator
    output skew_cmd_t skew_cmd,     // strobe plus direction
    output logic      busy,
    output logic      locked,
    output logic      fail
);

    localparam int EW     = `EDGE_W;
    localparam int SET_W  = $clog2(`SETTLE_FRAMES + 1);
    localparam int STEP_W = $clog2(`MAX_STEPS + 1);

    localparam logic [EW-1:0] TGT      = EW'(`TARGET_EDGE);
    localparam logic [EW-1:0] WRAP_ADD = EW'(`PAT_LEN - `TARGET_EDGE);
    localparam logic [EW-1:0] HALF     = EW'(`HALF_PAT);

    align_state_e      state;
    logic [SET_W-1:0]  settle_cnt;   // reports still to drop
    logic [STEP_W-1:0] step_cnt;     // steps issued since start
    logic [EW-1:0]     err;          // (edge_pos - target) mod 36
    skew_dir_e         want_dir;     // shorter way back to target
    logic              start_ok;     // start is only taken when not busy

    // cyclic error, no real divider needed
    always_comb begin
        if (rpt.edge_pos >= TGT) begin
            err = rpt.edge_pos - TGT;
        end else begin
            err = rpt.edge_pos + WRAP_ADD;
        end
        want_dir = (err <= HALF) ? DLY_DEC : DLY_INC;   // 1..18 late, else early
    end

    assign start_ok = start && ((state == IDLE) || (state == LOCKED) || (state == FAIL));

    // status decoded straight from state
    assign busy   = (state != IDLE) && (state != LOCKED) && (state != FAIL);
    assign locked = (state == LOCKED);
    assign fail   = (state == FAIL);

    always_ff @(posedge clk_9x) begin
        if (rst_9x) begin
            state      <= IDLE;
            settle_cnt <= '0;
            step_cnt   <= '0;
            skew_cmd   <= '{en: 1'b0, dir: DLY_DEC};
        end else begin
            if (start_ok) begin
                state      <= MEASURE;
                settle_cnt <= SET_W'(`SETTLE_FRAMES);   // first reports may be stale
                step_cnt   <= '0;
            end else begin
                case (state)
                    MEASURE: begin
                        if (rpt_valid) begin
                            if (settle_cnt != '0) begin
                                settle_cnt <= settle_cnt - 1'b1;   // drop it
                            end else if (!rpt.found) begin
                                state <= FAIL;                     // no edge came back
                            end else if (err == '0) begin
                                state <= LOCKED;
                            end else if (step_cnt == STEP_W'(`MAX_STEPS)) begin
                                state <= FAIL;                     // step budget spent
                            end else begin
                                skew_cmd.dir <= want_dir;
                                state        <= STEP;
                            end
                        end
                    end
                    STEP: begin
                        skew_cmd.en <= 1'b1;          // dir already stable
                        step_cnt    <= step_cnt + 1'b1;
                        state       <= WAIT_ACK;
                    end
                    WAIT_ACK: begin
                        if (skew_ack) begin
                            skew_cmd.en <= 1'b0;      // drop one cycle after ack
                            state       <= SETTLE;
                        end
                    end
                    SETTLE: begin
                        // ack must be low before the next strobe can count
                        if (!skew_ack) begin
                            settle_cnt <= SET_W'(`SETTLE_FRAMES);
                            state      <= MEASURE;
                        end
                    end
                    default: ;   // IDLE, LOCKED, FAIL wait for start
                endcase
            end
        end
    end

endmodule

//--- design/clk_align_pkg.sv
`include "clk_align_cfg.svh"

package clk_align_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE     = 3'd0,    // waiting for start
        MEASURE  = 3'd1,    // dropping settle reports, then judging one
        STEP     = 3'd2,    // raise skew strobe
        WAIT_ACK = 3'd3,    // hold strobe until pattern acks
        SETTLE   = 3'd4,    // wait for ack to drop
        LOCKED   = 3'd5,    // edge sits at target
        FAIL     = 3'd6     // no edge or too many steps
    } align_state_e;

    // direction of one skew step
    typedef enum logic {
        DLY_DEC = 1'b0,     // right rotate, edge moves to e-1
        DLY_INC = 1'b1      // left rotate, edge moves to e+1
    } skew_dir_e;

    // report from the edge finder, one per received frame
    typedef struct packed {
        logic [`EDGE_W-1:0] edge_pos;   // lowest rising edge sample index
        logic               found;      // clear when frame has no 0->1 transition
    } edge_rpt_t;

    // skew strobe toward the pattern generator
    typedef struct packed {
        logic      en;      // held high until ack
        skew_dir_e dir;     // valid while en is high
    } skew_cmd_t;

endpackage

//--- design/clk_align_top.sv
`include "clk_align_cfg.svh"

module clk_align_top
    import clk_align_pkg::*;
(
    input  logic               clk_9x,
    input  logic               rst_9x,
    input  logic               start,      // begin an alignment run
    input  logic [`WORD_W-1:0] rx_word,    // data samples back from the sensor
    output logic [`WORD_W-1:0] clk_word,   // serializer word for the sensor clock
    output logic               busy,
    output logic               locked,
    output logic               fail
);

    skew_cmd_t skew_cmd;      // ctrl -> pattern strobe
    logic      skew_ack;      // pattern -> ctrl
    logic      frame_start;   // slot 0 marker for the rx side
    edge_rpt_t rpt;           // finder -> ctrl
    logic      rpt_valid;

    // clock pattern with skew rotation
    sensor_clk_pattern u_pattern (
        .clk_9x      (clk_9x),
        .rst_9x      (rst_9x),
        .skew_cmd    (skew_cmd),
        .skew_ack    (skew_ack),
        .clk_word    (clk_word),
        .frame_start (frame_start)
    );

    // received frame edge search
    rx_edge_finder u_finder (
        .clk_9x      (clk_9x),
        .rst_9x      (rst_9x),
        .rx_word     (rx_word),
        .frame_start (frame_start),
        .rpt         (rpt),
        .rpt_valid   (rpt_valid)
    );

    // alignment loop
    alignment_ctrl u_ctrl (
        .clk_9x      (clk_9x),
        .rst_9x      (rst_9x),
        .start       (start),
        .rpt         (rpt),
        .rpt_valid   (rpt_valid),
        .skew_ack    (skew_ack),
        .skew_cmd    (skew_cmd),
        .busy        (busy),
        .locked      (locked),
        .fail        (fail)
    );

endmodule

//--- design/rx_edge_finder.sv
`include "clk_align_cfg.svh"

module rx_edge_finder
    import clk_align_pkg::*;
(
    input  logic               clk_9x,
    input  logic               rst_9x,
    input  logic [`WORD_W-1:0] rx_word,      // returned samples, bit 0 first
    input  logic               frame_start,  // rx_word is slot 0 this cycle
    output edge_rpt_t          rpt,          // edge of the last full frame
    output logic               rpt_valid     // one-cycle strobe with rpt
);

    localparam int SLOT_W = $clog2(`FRAME_SLOTS);
    localparam int EW     = `EDGE_W;

    logic [`PAT_LEN-1:0] frame_buf;      // bit i is sample i once 9 words are in
    logic [SLOT_W-1:0]   slot_cnt;       // slot of the next word to capture
    logic                capturing;      // inside a frame after slot 0
    logic                frame_done;     // slot 8 captured last edge
    logic                shift_en;

    // cyclic priority search, lowest i with s[i]=1 and s[i-1]=0
    function automatic edge_rpt_t find_rise(input logic [`PAT_LEN-1:0] s);
        edge_rpt_t r;
        r = '0;
        // descending so the lowest match is kept
        for (int i = `PAT_LEN - 1; i >= 0; i--) begin
            if (s[i] && !s[(i + `PAT_LEN - 1) % `PAT_LEN]) begin
                r.edge_pos = EW'(i);
                r.found    = 1'b1;
            end
        end
        return r;
    endfunction

    assign shift_en = frame_start || capturing;

    // frame buffer, new words enter at the top and walk down
    always_ff @(posedge clk_9x) begin
        if (shift_en) begin
            frame_buf <= {rx_word, frame_buf[`PAT_LEN-1:`WORD_W]};
        end
    end

    // slot counting
    always_ff @(posedge clk_9x) begin
        if (rst_9x) begin
            slot_cnt   <= '0;
            capturing  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (frame_start) begin
                slot_cnt  <= SLOT_W'(1);   // slot 0 goes in now
                capturing <= 1'b1;
            end else if (capturing) begin
                if (slot_cnt == SLOT_W'(`FRAME_SLOTS - 1)) begin
                    slot_cnt   <= '0;
                    capturing  <= 1'b0;
                    frame_done <= 1'b1;    // slot 0 now at bits 3:0
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end
        end
    end

    // report register
    always_ff @(posedge clk_9x) begin
        if (rst_9x) begin
            rpt_valid <= 1'b0;
        end else begin
            rpt_valid <= frame_done;
        end
    end

    always_ff @(posedge clk_9x) begin
        if (frame_done) begin
            rpt <= find_rise(frame_buf);   // position and found flag together
        end
    end

endmodule

//--- design/sensor_clk_pattern.sv
`include "clk_align_cfg.svh"

module sensor_clk_pattern
    import clk_align_pkg::*;
(
    input  logic               clk_9x,
    input  logic               rst_9x,       // sync, active high
    input  skew_cmd_t          skew_cmd,     // strobe from controller
    output logic               skew_ack,     // high from rotate until en drops
    output logic [`WORD_W-1:0] clk_word,     // next 4 serial samples, bit 0 first
    output logic               frame_start   // clk_word holds slot 0 this cycle
);

    localparam int SLOT_W = $clog2(`FRAME_SLOTS);

    // bit i is sample i of the clock period
    logic [`PAT_LEN-1:0] clk_pattern;
    logic [SLOT_W-1:0]   slot_idx;        // slot being loaded into clk_word
    logic                step_go;         // accept one strobe

    // word view of the pattern, slot k holds samples 4k..4k+3
    logic [`WORD_W-1:0]  slot_word [`FRAME_SLOTS];

    assign step_go = skew_cmd.en && !skew_ack;   // first cycle of a new strobe

    // rotation and handshake
    always_ff @(posedge clk_9x) begin
        if (rst_9x) begin
            // samples 0..17 low, 18..35 high, rising edge at 18
            clk_pattern <= {{(`PAT_LEN / 2){1'b1}}, {(`PAT_LEN / 2){1'b0}}};
            skew_ack    <= 1'b0;
        end else begin
            if (!skew_cmd.en) begin
                skew_ack <= 1'b0;   // release one cycle after en drops
            end

            if (step_go) begin
                skew_ack <= 1'b1;
                if (skew_cmd.dir == DLY_INC) begin
                    // left rotate, sample i takes sample i-1
                    clk_pattern <= {clk_pattern[`PAT_LEN-2:0], clk_pattern[`PAT_LEN-1]};
                end else begin
                    // right rotate, sample i takes sample i+1
                    clk_pattern <= {clk_pattern[0], clk_pattern[`PAT_LEN-1:1]};
                end
            end
        end
    end

    // slice the pattern into serializer words
    genvar k;
    generate
        for (k = 0; k < `FRAME_SLOTS; k++) begin : g_slot
            assign slot_word[k] = clk_pattern[k*`WORD_W +: `WORD_W];
        end
    endgenerate

    // slot sequencer and output word register
    always_ff @(posedge clk_9x) begin
        if (rst_9x) begin
            slot_idx    <= '0;
            clk_word    <= '0;
            frame_start <= 1'b0;
        end else begin
            if (slot_idx == SLOT_W'(`FRAME_SLOTS - 1)) begin
                slot_idx <= '0;               // wrap at 9
            end else begin
                slot_idx <= slot_idx + 1'b1;
            end

            clk_word    <= slot_word[slot_idx];
            frame_start <= (slot_idx == '0);  // lines up with slot 0 on clk_word
        end
    end

endmodule

//--- include/clk_align_cfg.svh
`ifndef CLK_ALIGN_CFG_SVH
`define CLK_ALIGN_CFG_SVH

// clock pattern geometry
`define PAT_LEN        36   // samples in one sensor clock period
`define WORD_W         4    // samples per clk_9x word, bit 0 leaves first
`define FRAME_SLOTS    9    // words per pattern period

// edge position reporting
`define EDGE_W         6    // wide enough for 0..35

// alignment target and loop limits
`define TARGET_EDGE    9    // wanted sample index of the received rising edge
`define SETTLE_FRAMES  2    // reports dropped after start and after each step
`define MAX_STEPS      40   // give up once this many steps were taken

// derived sizes
`define HALF_PAT       (`PAT_LEN / 2)   // err above this is shorter the other way

`endif
